//--- src.f
siFhPkg.sv
histogramPeak.sv
zoomWindow.sv
siFhTop.sv
siFhSva.sv
siFhTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= siFhTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- siFhTb.sv
module siFhTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NB = siFhPkg::NB_DEF;
    localparam int NF = siFhPkg::NF_DEF;
    localparam int NCB = 1 << NB;
    localparam int NFB = 1 << NF;
    localparam int W = 1 << (siFhPkg::NP - NB); // Coarse bin width
    localparam int RANGE = 1 << siFhPkg::NP;
    localparam int CNT_MAX = (1 << siFhPkg::CNT_W) - 1;
    localparam int NUM_PIX = 10;
    localparam int MAX_STAMPS = 400; // Per pixel, dropped stamps included

    logic            clk;
    logic            res;
    logic            stampValid;
    siFhPkg::stampT  stamp;
    logic            coarseEnd;
    logic            fineEnd;
    siFhPkg::pixelT  pixelId;
    logic            windowValid;
    siFhPkg::windowT window;
    logic            resultValid;
    siFhPkg::resultT result;

    siFhPkg::stampT  coarseQ[$];
    siFhPkg::stampT  fineQ[$];
    siFhPkg::windowT expWin[$];
    siFhPkg::resultT expRes[$];

    int cycle;
    int coarseEndCycle;
    int fineEndCycle;
    int winErrors;
    int resErrors;
    int latErrors;
    int otherErrors;

    siFhTop #(
        .NB(NB),
        .NF(NF)
    ) i_dut (
        .clk(clk),
        .res(res),
        .stampValid(stampValid),
        .stamp(stamp),
        .coarseEnd(coarseEnd),
        .fineEnd(fineEnd),
        .pixelId(pixelId),
        .windowValid(windowValid),
        .window(window),
        .resultValid(resultValid),
        .result(result)
    );

    always #2 clk = ~clk;

    // Expected window and result of one pixel from its stamp lists
    function automatic void refPixel(
        input  siFhPkg::stampT  cq[$],
        input  siFhPkg::stampT  fq[$],
        input  siFhPkg::pixelT  pix,
        output siFhPkg::windowT expW,
        output siFhPkg::resultT expR
    );
        int cCnt [NCB];
        int fCnt [NFB];
        int cBin;
        int cBest;
        int fBin;
        int fBest;
        int lower;
        int delta;
        int s;
        for (int i = 0; i < NCB; i++) begin
            cCnt[i] = 0;
        end
        for (int i = 0; i < NFB; i++) begin
            fCnt[i] = 0;
        end
        foreach (cq[i]) begin
            s = int'(cq[i]) / W;
            if (cCnt[s] < CNT_MAX) cCnt[s]++;
        end
        cBin = 0;
        cBest = 0;
        for (int i = 0; i < NCB; i++) begin
            if (cCnt[i] > cBest) begin // Ties stay with the lower bin
                cBest = cCnt[i];
                cBin = i;
            end
        end
        lower = cBin * W + W / 2 - W;
        if (lower < 0) begin
            lower = 0;
        end else if (lower > RANGE - 2 * W) begin
            lower = RANGE - 2 * W;
        end
        delta = 2 * W / NFB;
        foreach (fq[i]) begin
            s = int'(fq[i]);
            if (s >= lower && s < lower + 2 * W) begin
                s = (s - lower) / delta;
                if (fCnt[s] < CNT_MAX) fCnt[s]++;
            end
        end
        fBin = 0;
        fBest = 0;
        for (int i = 0; i < NFB; i++) begin
            if (fCnt[i] > fBest) begin
                fBest = fCnt[i];
                fBin = i;
            end
        end
        expW.lower = siFhPkg::stampT'(lower);
        expW.fineDelta = siFhPkg::stampT'(delta);
        expR.pixel = pix;
        expR.fineStamp = siFhPkg::stampT'(lower + fBin * delta + delta / 2);
        expR.peakCount = siFhPkg::countT'(fBest);
        expR.lower = expW.lower;
        expR.fineDelta = expW.fineDelta;
    endfunction

    function automatic siFhPkg::stampT randStamp();
        return siFhPkg::stampT'($urandom_range(RANGE - 1));
    endfunction

    task automatic checkWindow(input siFhPkg::windowT exp, input siFhPkg::windowT act);
        if (act !== exp) begin
            winErrors++;
            $display("ERR %0t window exp lower=%h fineDelta=%h act lower=%h fineDelta=%h",
                     $time, exp.lower, exp.fineDelta, act.lower, act.fineDelta);
        end
    endtask

    task automatic checkResult(input siFhPkg::resultT exp, input siFhPkg::resultT act);
        if (act !== exp) begin
            resErrors++;
            $write("ERR %0t result exp pixel=%h fineStamp=%h peakCount=%h lower=%h fineDelta=%h",
                   $time, exp.pixel, exp.fineStamp, exp.peakCount, exp.lower, exp.fineDelta);
            $display(" act pixel=%h fineStamp=%h peakCount=%h lower=%h fineDelta=%h",
                     act.pixel, act.fineStamp, act.peakCount, act.lower, act.fineDelta);
        end
    endtask

    task automatic latencyCheck(input string name, input int exp, input int act);
        if (act != exp) begin
            latErrors++;
            $display("ERR %0t %s exp %0d act %0d", $time, name, exp, act);
        end
    endtask

    // n stamps spread over [lo, lo + span)
    task automatic addCoarse(input int lo, input int span, input int n);
        repeat (n) begin
            coarseQ.push_back(siFhPkg::stampT'(lo + $urandom_range(span - 1)));
        end
    endtask

    // Builds the fine list around the expected window, then plays both phases
    task automatic runPixel(input siFhPkg::pixelT pix, input int nHot, input int hotBin,
                            input int nIn, input int nOut, input int nDrop);
        siFhPkg::windowT w;
        siFhPkg::resultT r;
        int lower;
        int delta;
        fineQ.delete();
        refPixel(coarseQ, fineQ, pix, w, r);
        lower = int'(w.lower);
        delta = int'(w.fineDelta);
        repeat (nHot) begin
            fineQ.push_back(siFhPkg::stampT'(lower + hotBin * delta + $urandom_range(delta - 1)));
        end
        repeat (nIn) begin
            fineQ.push_back(siFhPkg::stampT'(lower + $urandom_range(2 * W - 1)));
        end
        repeat (nOut) begin // Outside the window, must be ignored
            if (lower > 0) begin
                fineQ.push_back(siFhPkg::stampT'($urandom_range(lower - 1)));
            end else begin
                fineQ.push_back(siFhPkg::stampT'(2 * W + $urandom_range(RANGE - 2 * W - 1)));
            end
        end
        refPixel(coarseQ, fineQ, pix, w, r);
        expWin.push_back(w);
        expRes.push_back(r);

        @(posedge clk);
        pixelId <= pix;
        foreach (coarseQ[i]) begin
            @(posedge clk);
            stampValid <= 1'b1;
            stamp <= coarseQ[i];
            coarseEnd <= (i == coarseQ.size() - 1); // Last hit shares the end cycle
        end
        if (coarseQ.size() == 0) begin
            @(posedge clk);
            coarseEnd <= 1'b1;
        end
        repeat (nDrop) begin // Lands during SCAN
            @(posedge clk);
            coarseEnd <= 1'b0;
            stampValid <= 1'b1;
            stamp <= randStamp();
        end
        @(posedge clk);
        stampValid <= 1'b0;
        coarseEnd <= 1'b0;
        do @(posedge clk); while (!windowValid);

        foreach (fineQ[i]) begin
            @(posedge clk);
            stampValid <= 1'b1;
            stamp <= fineQ[i];
        end
        @(posedge clk);
        stampValid <= 1'b0;
        fineEnd <= 1'b1;
        repeat (nDrop) begin
            @(posedge clk);
            fineEnd <= 1'b0;
            stampValid <= 1'b1;
            stamp <= randStamp();
        end
        @(posedge clk);
        stampValid <= 1'b0;
        fineEnd <= 1'b0;
        do @(posedge clk); while (!resultValid);
        coarseQ.delete();
    endtask

    // Compare every valid pulse with the oldest pending expectation
    always @(posedge clk) begin
        if (res) begin
            if (coarseEnd) coarseEndCycle = cycle;
            if (fineEnd) fineEndCycle = cycle;
            if (windowValid) begin
                if (expWin.size() == 0) begin
                    otherErrors++;
                    $display("Unexpected windowValid pulse at %0t with no pixel pending", $time);
                end else begin
                    latencyCheck("windowValid latency", NCB + 2, cycle - coarseEndCycle);
                    checkWindow(expWin.pop_front(), window);
                end
            end
            if (resultValid) begin
                if (expRes.size() == 0) begin
                    otherErrors++;
                    $display("Unexpected resultValid pulse at %0t with no pixel pending", $time);
                end else begin
                    latencyCheck("resultValid latency", NFB + 2, cycle - fineEndCycle);
                    checkResult(expRes.pop_front(), result);
                end
            end
        end
        cycle <= cycle + 1;
    end

    initial begin
        repeat (16 + NUM_PIX * (MAX_STAMPS + NCB + NFB + 20)) @(posedge clk);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h4bb8));
        clk = 1'b0;
        res = 1'b0;
        stampValid = 1'b0;
        stamp = '0;
        coarseEnd = 1'b0;
        fineEnd = 1'b0;
        pixelId = '0;
        cycle = 0;
        coarseEndCycle = 0;
        fineEndCycle = 0;
        winErrors = 0;
        resErrors = 0;
        latErrors = 0;
        otherErrors = 0;
        repeat (16) @(posedge clk);
        res <= 1'b1;
        repeat (2) @(posedge clk);

        // Cluster mid range plus background noise
        addCoarse(1900, 160, 30);
        addCoarse(0, RANGE, 10);
        runPixel(6'd1, 20, $urandom_range(NFB - 1), 10, 8, 0);
        // Peak in bin 0, window clamped low
        addCoarse(0, W, 25);
        runPixel(6'd2, 15, 2, 15, 8, 2);
        // Peak in the top bin, window clamped high
        addCoarse(RANGE - W, W, 25);
        runPixel(6'd3, 15, NFB - 1, 15, 8, 3);
        // Equal counts in bins 9 and 3, higher bin sent first
        addCoarse(9 * W, W, 6);
        addCoarse(3 * W, W, 6);
        runPixel(6'd4, 10, 7, 10, 6, 4);
        runPixel(6'd5, 0, 0, 0, 0, 8); // No hits at all
        // Fine counter saturation
        addCoarse(8 * W, W, 20);
        runPixel(6'd6, 300, 5, 20, 6, 2);
        for (int p = 7; p <= NUM_PIX; p++) begin
            addCoarse($urandom_range(RANGE - 200), 200, 20 + $urandom_range(20));
            addCoarse(0, RANGE, 8);
            runPixel(siFhPkg::pixelT'(p), 10 + $urandom_range(20), $urandom_range(NFB - 1),
                     20, 8, $urandom_range(8));
        end

        repeat (4) @(posedge clk);
        if (expWin.size() != 0 || expRes.size() != 0) begin
            otherErrors++;
            $display("%0d windows and %0d results were expected but never arrived",
                     expWin.size(), expRes.size());
        end
        $display("Errors: window %0d, result %0d, latency %0d, other %0d",
                 winErrors, resErrors, latErrors, otherErrors);
        if (winErrors + resErrors + latErrors + otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- siFhSva.sv
module siFhSva #(
    parameter int NB = 4
) (
    input  logic            clk,
    input  logic            res,
    input  logic            windowValid,
    input  siFhPkg::windowT window,
    input  logic            resultValid
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int W = 1 << (siFhPkg::NP - NB); // Coarse bin width
    localparam int RANGE = 1 << siFhPkg::NP;

    windowPulse: assert property (@(posedge clk) disable iff (!res)
        windowValid |=> !windowValid)
        else $error("windowValid stayed high for more than one cycle");

    resultPulse: assert property (@(posedge clk) disable iff (!res)
        resultValid |=> !resultValid)
        else $error("resultValid stayed high for more than one cycle");

    // Window of 2W must fit inside the stamp range
    windowRange: assert property (@(posedge clk) disable iff (!res)
        windowValid |-> (int'(window.lower) + 2 * W <= RANGE))
        else $error("zoom window runs past the end of the timestamp range");

    quietInReset: assert property (@(posedge clk) !res |-> !resultValid)
        else $error("resultValid high while reset is asserted");

endmodule

bind siFhTop siFhSva #(
    .NB(NB)
) sva (
    .clk(clk),
    .res(res),
    .windowValid(windowValid),
    .window(window),
    .resultValid(resultValid)
);

//--- siFhTop.sv
module siFhTop #(
    parameter int NB = siFhPkg::NB_DEF,
    parameter int NF = siFhPkg::NF_DEF
) (
    input  logic                clk,
    input  logic                res,
    input  logic                stampValid,
    input  siFhPkg::stampT      stamp,
    input  logic                coarseEnd,
    input  logic                fineEnd,
    input  siFhPkg::pixelT      pixelId,
    output logic                windowValid,
    output siFhPkg::windowT     window,
    output logic                resultValid,
    output siFhPkg::resultT     result
);

    logic           coarseHit;
    logic           coarseValid;
    logic [NB-1:0]  coarseBin;
    logic           fineHit;
    logic [NF-1:0]  fineBin;
    logic           fineValid;
    logic [NF-1:0]  fineBinPeak;
    siFhPkg::countT finePeakCount;
    logic           fineActive;

    // Fine phase stamps stay out of the next pixel's coarse histogram
    assign coarseHit = stampValid && !fineActive;

    histogramPeak #(
        .BIN_W(NB)
    ) coarseHist (
        .clk(clk),
        .res(res),
        .hit(coarseHit),
        .bin(stamp[siFhPkg::NP-1 -: NB]), // Top bits select the coarse bin
        .phaseEnd(coarseEnd),
        .peakValid(coarseValid),
        .peakBin(coarseBin),
        .peakCount() // Only the fine count is reported
    );

    histogramPeak #(
        .BIN_W(NF)
    ) fineHist (
        .clk(clk),
        .res(res),
        .hit(fineHit),
        .bin(fineBin),
        .phaseEnd(fineEnd),
        .peakValid(fineValid),
        .peakBin(fineBinPeak),
        .peakCount(finePeakCount)
    );

    zoomWindow #(
        .NB(NB),
        .NF(NF)
    ) zoom (
        .clk(clk),
        .res(res),
        .pixelId(pixelId),
        .stampValid(stampValid),
        .stamp(stamp),
        .coarseValid(coarseValid),
        .coarseBin(coarseBin),
        .fineValid(fineValid),
        .fineBinPeak(fineBinPeak),
        .finePeakCount(finePeakCount),
        .windowValid(windowValid),
        .window(window),
        .fineHit(fineHit),
        .fineBin(fineBin),
        .fineActive(fineActive),
        .resultValid(resultValid),
        .result(result)
    );

endmodule

//--- zoomWindow.sv
module zoomWindow #(
    parameter int NB = 4,
    parameter int NF = 4
) (
    input  logic                clk,
    input  logic                res,
    input  siFhPkg::pixelT      pixelId,
    input  logic                stampValid,
    input  siFhPkg::stampT      stamp,
    input  logic                coarseValid,
    input  logic [NB-1:0]       coarseBin,
    input  logic                fineValid,
    input  logic [NF-1:0]       fineBinPeak,
    input  siFhPkg::countT      finePeakCount,
    output logic                windowValid,
    output siFhPkg::windowT     window,
    output logic                fineHit,
    output logic [NF-1:0]       fineBin,
    output logic                fineActive,
    output logic                resultValid,
    output siFhPkg::resultT     result
);

    localparam int NP = siFhPkg::NP;

    // Coarse bin width W and fine bin width as powers of two
    localparam int W_LOG = NP - NB;
    localparam int W = 1 << W_LOG;
    localparam int DELTA_LOG = W_LOG + 1 - NF;
    localparam int FINE_DELTA = 1 << DELTA_LOG;
    localparam int LOWER_MAX = (1 << NP) - 2 * W;

    // Window span 2W can reach 2**NP, hence the extra bit
    localparam logic [NP:0] SPAN = (NP + 1)'(2 * W);

    siFhPkg::stampT nextLower;
    siFhPkg::pixelT pixelReg;   // Pixel tag of the window in use
    siFhPkg::stampT offset;
    logic           inWindow;
    siFhPkg::stampT fineStamp;

    // Centre the window on the coarse peak and clamp to the stamp range
    always_comb begin : lowerCalc
        int centre;
        int clamped;
        centre = int'(coarseBin) * W + W / 2;
        clamped = centre - W;
        if (clamped < 0) begin
            clamped = 0;
        end else if (clamped > LOWER_MAX) begin
            clamped = LOWER_MAX;
        end
        nextLower = siFhPkg::stampT'(clamped);
    end

    // Fine binning of stamps relative to the window start
    assign offset = stamp - window.lower;
    assign inWindow = (stamp >= window.lower) && ({1'b0, offset} < SPAN);

    // Back to a timestamp at the centre of the winning fine bin
    assign fineStamp = window.lower
                     + (siFhPkg::stampT'(fineBinPeak) << DELTA_LOG)
                     + siFhPkg::stampT'(FINE_DELTA / 2);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            windowValid <= 1'b0;
            fineHit <= 1'b0;
            fineActive <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            windowValid <= coarseValid;
            resultValid <= fineValid;
            fineHit <= stampValid && fineActive && inWindow;
            // Fine phase runs from the window to the fine peak
            if (coarseValid) begin
                fineActive <= 1'b1;
            end else if (fineValid) begin
                fineActive <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (coarseValid) begin
            window.lower <= nextLower;
            window.fineDelta <= siFhPkg::stampT'(FINE_DELTA);
            pixelReg <= pixelId; // Held stable by the source until the result
        end
        if (stampValid) begin
            fineBin <= NF'(offset >> DELTA_LOG);
        end
        if (fineValid) begin
            result.pixel <= pixelReg;
            result.fineStamp <= fineStamp;
            result.peakCount <= finePeakCount;
            result.lower <= window.lower;
            result.fineDelta <= window.fineDelta;
        end
    end

endmodule

//--- histogramPeak.sv
module histogramPeak #(
    parameter int BIN_W = 4
) (
    input  logic                clk,
    input  logic                res,
    input  logic                hit,
    input  logic [BIN_W-1:0]    bin,
    input  logic                phaseEnd,
    output logic                peakValid,
    output logic [BIN_W-1:0]    peakBin,
    output siFhPkg::countT      peakCount
);

    localparam int NBINS = 1 << BIN_W;

    siFhPkg::histStateT state;

    // One saturating counter per bin
    siFhPkg::countT countMem [NBINS];

    logic [BIN_W-1:0] ptr;       // Scan pointer
    siFhPkg::countT   bestCount; // Running maximum
    logic [BIN_W-1:0] bestBin;

    siFhPkg::countT   curCount;
    logic             takeCur;
    siFhPkg::countT   nextCount;
    logic [BIN_W-1:0] nextBin;
    logic             lastBin;

    // Compare the bin under the pointer with the best so far
    always_comb begin
        curCount = countMem[ptr];
        takeCur = curCount > bestCount; // Strict, so ties keep the lower index
        nextCount = takeCur ? curCount : bestCount;
        nextBin = takeCur ? ptr : bestBin;
        lastBin = &ptr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= siFhPkg::IDLE;
            ptr <= '0;
            peakValid <= 1'b0;
            for (int i = 0; i < NBINS; i++) begin
                countMem[i] <= '0;
            end
        end else begin
            peakValid <= 1'b0;
            case (state)
                siFhPkg::IDLE: begin
                    // A hit on the end cycle still lands before the scan starts
                    if (hit && (countMem[bin] != '1)) begin
                        countMem[bin] <= countMem[bin] + siFhPkg::countT'(1);
                    end
                    if (phaseEnd) begin
                        state <= siFhPkg::SCAN;
                        ptr <= '0;
                    end
                end
                siFhPkg::SCAN: begin
                    countMem[ptr] <= '0; // Clear behind the scan
                    ptr <= ptr + 1'b1;
                    if (lastBin) begin
                        state <= siFhPkg::IDLE;
                        peakValid <= 1'b1;
                    end
                end
                default: state <= siFhPkg::IDLE;
            endcase
        end
    end

    // Running maximum and published peak
    always_ff @(posedge clk) begin
        if (state == siFhPkg::IDLE) begin
            bestCount <= '0; // No hits at all gives bin 0, count 0
            bestBin <= '0;
        end else begin
            bestCount <= nextCount;
            bestBin <= nextBin;
        end
        if (state == siFhPkg::SCAN && lastBin) begin
            peakBin <= nextBin;
            peakCount <= nextCount;
        end
    end

endmodule

//--- siFhPkg.sv
package siFhPkg;

    // Timestamp range is 2**NP ticks
    localparam int NP = 12;

    // Counters saturate at all ones
    localparam int CNT_W = 8;

    localparam int PIX_W = 6;

    // Bin index widths used when the top level is not overridden
    localparam int NB_DEF = 4; // Coarse bin index bits
    localparam int NF_DEF = 4; // Fine bin index bits

    typedef logic [NP-1:0] stampT;
    typedef logic [CNT_W-1:0] countT;
    typedef logic [PIX_W-1:0] pixelT;

    // Zoom window as seen by the fine phase
    typedef struct packed {
        stampT lower;     // First stamp inside the window
        stampT fineDelta; // Width of one fine bin
    } windowT;

    // One finished pixel
    typedef struct packed {
        pixelT pixel;
        stampT fineStamp; // Centre of the winning fine bin
        countT peakCount; // Hits in the winning fine bin
        stampT lower;
        stampT fineDelta;
    } resultT;

    typedef enum logic {
        IDLE,
        SCAN
    } histStateT;

endpackage
